// ==== src/RiscvPkg.sv ====
package RiscvPkg;

	localparam int XLEN = 32; // Data and address width
	localparam int RegNumWidth = 5;
	localparam int RegCount = 2 ** RegNumWidth;
	localparam int Func3Width = 3;
	localparam int DmemWords = 64; // Data memory depth in words
	localparam int DmemAddrWidth = $clog2(DmemWords);

	// Sequential instruction step
	localparam logic [XLEN-1:0] PcStep = 4;

	// RV32I major opcodes
	typedef enum logic [6:0]
	{
		OpImm  = 7'b0010011,
		Op     = 7'b0110011,
		Lui    = 7'b0110111,
		Auipc  = 7'b0010111,
		Jal    = 7'b1101111,
		Jalr   = 7'b1100111,
		Branch = 7'b1100011,
		Load   = 7'b0000011,
		Store  = 7'b0100011
	} Opcode;

	typedef enum logic [3:0]
	{
		Add,
		Sub,
		Sll,
		Slt,
		Sltu,
		Xor,
		Srl,
		Sra,
		Or,
		And,
		PassB // Second ALU input straight through
	} AluOp;

	// Operand source, execute beats write-back beats register file
	typedef enum logic [1:0]
	{
		FromReg,
		FromExecute,
		FromWriteBack
	} FwdSel;

endpackage

// ==== src/DataMemory.sv ====
`timescale 1ns/1ns
module DataMemory (
	input  logic                               clk,
	input  logic                               writeEnable,
	input  logic [RiscvPkg::DmemAddrWidth-1:0] address,
	input  logic [RiscvPkg::XLEN-1:0]          writeData,
	output logic [RiscvPkg::XLEN-1:0]          readData
);

	logic [RiscvPkg::XLEN-1:0] mem [RiscvPkg::DmemWords];

	initial
	begin
		for (int i = 0; i < RiscvPkg::DmemWords; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk)
	begin
		if (writeEnable)
			mem[address] <= writeData;
		readData <= mem[address]; // Old data on a same-cycle write
	end

endmodule

// ==== src/RegsFile.sv ====
`timescale 1ns/1ns
module RegsFile (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic [RiscvPkg::RegNumWidth-1:0] readNum0,
	input  logic [RiscvPkg::RegNumWidth-1:0] readNum1,
	output logic [RiscvPkg::XLEN-1:0]        readData0,
	output logic [RiscvPkg::XLEN-1:0]        readData1,
	input  logic                             writeEnable,
	input  logic [RiscvPkg::RegNumWidth-1:0] writeNum,
	input  logic [RiscvPkg::XLEN-1:0]        writeData
);

	logic [RiscvPkg::XLEN-1:0] regs [RiscvPkg::RegCount];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < RiscvPkg::RegCount; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && writeNum != '0)
		begin
			regs[writeNum] <= writeData; // x0 stays zero
		end
	end

	assign readData0 = regs[readNum0];
	assign readData1 = regs[readNum1];

endmodule

// ==== src/Forward.sv ====
`timescale 1ns/1ns
module Forward (
	input  logic [RiscvPkg::RegNumWidth-1:0] srcNum0,
	input  logic [RiscvPkg::RegNumWidth-1:0] srcNum1,
	input  logic [RiscvPkg::RegNumWidth-1:0] exRd,
	input  logic                             exWritesReg,
	input  logic                             exIsLoad,
	input  logic [RiscvPkg::RegNumWidth-1:0] wbNum,
	input  logic                             wbEnable,
	output RiscvPkg::FwdSel                  selA,
	output RiscvPkg::FwdSel                  selB
);

	function automatic RiscvPkg::FwdSel pick(input logic [RiscvPkg::RegNumWidth-1:0] src);
		if (src != '0 && exWritesReg && !exIsLoad && src == exRd)
			pick = RiscvPkg::FromExecute; // Newest value wins
		else if (src != '0 && wbEnable && src == wbNum)
			pick = RiscvPkg::FromWriteBack;
		else
			pick = RiscvPkg::FromReg;
	endfunction

	assign selA = pick(srcNum0);
	assign selB = pick(srcNum1);

endmodule

// ==== src/Hazard.sv ====
`timescale 1ns/1ns
module Hazard (
	input  logic                             exValid,
	input  logic                             exIsLoad,
	input  logic [RiscvPkg::RegNumWidth-1:0] exRd,
	input  logic [RiscvPkg::RegNumWidth-1:0] srcNum0,
	input  logic [RiscvPkg::RegNumWidth-1:0] srcNum1,
	input  logic                             srcUses0,
	input  logic                             srcUses1,
	output logic                             stall
);

	logic match0;
	logic match1;

	assign match0 = srcUses0 && srcNum0 == exRd;
	assign match1 = srcUses1 && srcNum1 == exRd;

	// Load result is only ready in write-back
	assign stall = exValid && exIsLoad && exRd != '0 && (match0 || match1);

endmodule

// ==== src/Execute.sv ====
`timescale 1ns/1ns
module Execute (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             exValid,
	input  RiscvPkg::AluOp                   exOp,
	input  RiscvPkg::Opcode                  exOpcode,
	input  logic [RiscvPkg::Func3Width-1:0]  exFunc3,
	input  logic [RiscvPkg::XLEN-1:0]        operand0,
	input  logic [RiscvPkg::XLEN-1:0]        operand1,
	input  logic [RiscvPkg::XLEN-1:0]        imm,
	input  logic [RiscvPkg::XLEN-1:0]        exPc,
	input  logic [RiscvPkg::RegNumWidth-1:0] exRd,
	input  logic                             exWritesReg,
	output logic [RiscvPkg::XLEN-1:0]        aluResult,
	output logic                             redirect,
	output logic [RiscvPkg::XLEN-1:0]        redirectPc,
	output logic                             writeEnable,
	output logic [RiscvPkg::RegNumWidth-1:0] writeNum,
	output logic [RiscvPkg::XLEN-1:0]        writeData
);

	logic [RiscvPkg::XLEN-1:0] aluB;
	logic [RiscvPkg::XLEN-1:0] aluOut;
	logic [4:0] shamt;
	logic [RiscvPkg::XLEN-1:0] linkPc;
	logic [RiscvPkg::XLEN-1:0] jalrSum;
	logic isJump;
	logic takeBranch;
	logic memWrite;
	logic [RiscvPkg::XLEN-1:0] memReadData;
	logic [RiscvPkg::XLEN-1:0] wbResult;
	logic wbIsLoad;

	assign aluB = (exOpcode inside {RiscvPkg::OpImm, RiscvPkg::Load, RiscvPkg::Store}) ?
		imm : operand1;
	assign shamt = aluB[4:0];

	always_comb
	begin
		case (exOp)
			RiscvPkg::Add: aluOut = operand0 + aluB;
			RiscvPkg::Sub: aluOut = operand0 - aluB;
			RiscvPkg::Sll: aluOut = operand0 << shamt;
			RiscvPkg::Slt: aluOut = {{(RiscvPkg::XLEN-1){1'b0}}, $signed(operand0) < $signed(aluB)};
			RiscvPkg::Sltu: aluOut = {{(RiscvPkg::XLEN-1){1'b0}}, operand0 < aluB};
			RiscvPkg::Xor: aluOut = operand0 ^ aluB;
			RiscvPkg::Srl: aluOut = operand0 >> shamt;
			RiscvPkg::Sra: aluOut = $unsigned($signed(operand0) >>> shamt);
			RiscvPkg::Or: aluOut = operand0 | aluB;
			RiscvPkg::And: aluOut = operand0 & aluB;
			RiscvPkg::PassB: aluOut = aluB; // LUI
			default: aluOut = '0;
		endcase
	end

	always_comb
	begin
		case (exFunc3)
			3'b000: takeBranch = operand0 == operand1; // BEQ
			3'b001: takeBranch = operand0 != operand1;
			3'b100: takeBranch = $signed(operand0) < $signed(operand1);
			3'b101: takeBranch = $signed(operand0) >= $signed(operand1);
			3'b110: takeBranch = operand0 < operand1;
			3'b111: takeBranch = operand0 >= operand1; // BGEU
			default: takeBranch = 1'b0;
		endcase
	end

	assign isJump = exOpcode == RiscvPkg::Jal || exOpcode == RiscvPkg::Jalr;
	assign linkPc = exPc + RiscvPkg::PcStep;
	assign jalrSum = operand0 + imm;

	assign aluResult = isJump ? linkPc : aluOut; // Link value for JAL and JALR

	assign redirect = exValid && (isJump || (exOpcode == RiscvPkg::Branch && takeBranch));
	assign redirectPc = (exOpcode == RiscvPkg::Jalr) ?
		{jalrSum[RiscvPkg::XLEN-1:1], 1'b0} : exPc + imm;

	assign memWrite = exValid && exOpcode == RiscvPkg::Store;

	DataMemory dataMemory (
		.clk        (clk),
		.writeEnable(memWrite),
		.address    (aluOut[RiscvPkg::DmemAddrWidth+1:2]), // Word address
		.writeData  (operand1),
		.readData   (memReadData)
	);

	always_ff @(posedge clk)
	begin
		if (!rstN)
			writeEnable <= 1'b0;
		else
			writeEnable <= exValid && exWritesReg;
	end

	always_ff @(posedge clk)
	begin
		writeNum <= exRd;
		wbResult <= aluResult;
		wbIsLoad <= exOpcode == RiscvPkg::Load;
	end

	// Load data arrives from memory in this stage
	assign writeData = wbIsLoad ? memReadData : wbResult;

	NoWriteToZero: assert property (
		@(posedge clk) disable iff (!rstN)
		writeEnable |-> writeNum != '0
	);

endmodule

// ==== src/FetchUnit.sv ====
`timescale 1ns/1ns
module FetchUnit (
	input  logic                      clk,
	input  logic                      rstN,
	input  logic                      stall,
	input  logic                      redirect,
	input  logic [RiscvPkg::XLEN-1:0] redirectPc,
	output logic [RiscvPkg::XLEN-1:0] pc
);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			pc <= '0;
		end
		else if (redirect)
		begin
			pc <= redirectPc; // Taken branch or jump from execute
		end
		else if (!stall)
		begin
			pc <= pc + RiscvPkg::PcStep;
		end
	end

	// Only a load in execute stalls, and loads never redirect.
	// A redirect must win outright since it flushes the stalled instruction.
	StallRedirectExclusive: assert property (
		@(posedge clk) disable iff (!rstN)
		!(stall && redirect)
	);

endmodule

// ==== src/Decode.sv ====
`timescale 1ns/1ns
module Decode (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic [RiscvPkg::XLEN-1:0]        instr,
	input  logic [RiscvPkg::XLEN-1:0]        pc,
	output logic                             stall,
	output logic                             redirect,
	output logic [RiscvPkg::XLEN-1:0]        redirectPc,
	output logic                             wbEnable,
	output logic [RiscvPkg::RegNumWidth-1:0] wbReg,
	output logic [RiscvPkg::XLEN-1:0]        wbData
);

	RiscvPkg::Opcode opcode;
	RiscvPkg::AluOp aluOp;
	logic [RiscvPkg::Func3Width-1:0] func3;
	logic [RiscvPkg::RegNumWidth-1:0] rd;
	logic [RiscvPkg::RegNumWidth-1:0] rs1;
	logic [RiscvPkg::RegNumWidth-1:0] rs2;
	logic legal;
	logic hasRd;
	logic uses0;
	logic uses1;
	logic [RiscvPkg::XLEN-1:0] imm;
	logic [RiscvPkg::XLEN-1:0] readData0;
	logic [RiscvPkg::XLEN-1:0] readData1;
	logic [RiscvPkg::XLEN-1:0] operand0Next;
	logic [RiscvPkg::XLEN-1:0] operand1Next;
	RiscvPkg::FwdSel selA;
	RiscvPkg::FwdSel selB;

	logic exValid; // Execute stage registers
	logic exWritesReg;
	RiscvPkg::AluOp exOp;
	RiscvPkg::Opcode exOpcode;
	logic [RiscvPkg::Func3Width-1:0] exFunc3;
	logic [RiscvPkg::XLEN-1:0] exOperand0;
	logic [RiscvPkg::XLEN-1:0] exOperand1;
	logic [RiscvPkg::XLEN-1:0] exImm;
	logic [RiscvPkg::XLEN-1:0] exPc;
	logic [RiscvPkg::RegNumWidth-1:0] exRd;
	logic exIsLoad;

	logic [RiscvPkg::XLEN-1:0] aluResult; // From execute
	logic writeEnable;
	logic [RiscvPkg::RegNumWidth-1:0] writeNum;
	logic [RiscvPkg::XLEN-1:0] writeData;

	function automatic RiscvPkg::AluOp aluFromFunct(
		input logic [RiscvPkg::Func3Width-1:0] f3,
		input logic alt,
		input logic isReg
	);
		case (f3)
			3'b000:
				if (isReg && alt)
					aluFromFunct = RiscvPkg::Sub;
				else
					aluFromFunct = RiscvPkg::Add; // ADDI has no SUBI
			3'b001: aluFromFunct = RiscvPkg::Sll;
			3'b010: aluFromFunct = RiscvPkg::Slt;
			3'b011: aluFromFunct = RiscvPkg::Sltu;
			3'b100: aluFromFunct = RiscvPkg::Xor;
			3'b101:
				if (alt)
					aluFromFunct = RiscvPkg::Sra;
				else
					aluFromFunct = RiscvPkg::Srl;
			3'b110: aluFromFunct = RiscvPkg::Or;
			default: aluFromFunct = RiscvPkg::And;
		endcase
	endfunction

	function automatic logic [RiscvPkg::XLEN-1:0] pickOperand(
		input RiscvPkg::FwdSel sel,
		input logic [RiscvPkg::XLEN-1:0] regData
	);
		case (sel)
			RiscvPkg::FromExecute: pickOperand = aluResult;
			RiscvPkg::FromWriteBack: pickOperand = writeData;
			default: pickOperand = regData;
		endcase
	endfunction

	assign opcode = RiscvPkg::Opcode'(instr[6:0]);
	assign func3 = instr[14:12];
	assign rd = instr[11:7];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	always_comb
	begin
		legal = 1'b1;
		hasRd = 1'b1;
		uses0 = 1'b0;
		uses1 = 1'b0;
		aluOp = RiscvPkg::Add;
		imm = {{(RiscvPkg::XLEN-12){instr[31]}}, instr[31:20]}; // I format
		case (opcode)
			RiscvPkg::OpImm:
			begin
				uses0 = 1'b1;
				aluOp = aluFromFunct(func3, instr[30], 1'b0);
				if (func3 == 3'b001 || func3 == 3'b101)
					imm = {{(RiscvPkg::XLEN-12){1'b0}}, instr[31:20]}; // Unsigned shamt
			end
			RiscvPkg::Op:
			begin
				uses0 = 1'b1;
				uses1 = 1'b1;
				aluOp = aluFromFunct(func3, instr[30], 1'b1);
			end
			RiscvPkg::Lui:
			begin
				aluOp = RiscvPkg::PassB;
				imm = {instr[31:12], 12'b0};
			end
			RiscvPkg::Auipc:
				imm = {instr[31:12], 12'b0};
			RiscvPkg::Jal:
				imm = {{(RiscvPkg::XLEN-20){instr[31]}}, instr[19:12], instr[20],
					instr[30:21], 1'b0};
			RiscvPkg::Jalr:
				uses0 = 1'b1;
			RiscvPkg::Branch:
			begin
				hasRd = 1'b0;
				uses0 = 1'b1;
				uses1 = 1'b1;
				aluOp = RiscvPkg::Sub;
				imm = {{(RiscvPkg::XLEN-12){instr[31]}}, instr[7], instr[30:25],
					instr[11:8], 1'b0};
			end
			RiscvPkg::Load:
				uses0 = 1'b1;
			RiscvPkg::Store:
			begin
				hasRd = 1'b0;
				uses0 = 1'b1;
				uses1 = 1'b1;
				imm = {{(RiscvPkg::XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
			end
			default:
			begin
				legal = 1'b0; // Unsupported, never issued
				hasRd = 1'b0;
			end
		endcase
	end

	// Forwarded operands, LUI and AUIPC substitute their own inputs
	always_comb
	begin
		operand0Next = pickOperand(selA, readData0);
		operand1Next = pickOperand(selB, readData1);
		if (opcode == RiscvPkg::Lui)
		begin
			operand1Next = imm;
		end
		else if (opcode == RiscvPkg::Auipc)
		begin
			operand0Next = pc;
			operand1Next = imm;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			exValid <= 1'b0;
			exWritesReg <= 1'b0;
		end
		else
		begin
			exValid <= legal && !stall && !redirect; // Bubble on stall or flush
			exWritesReg <= legal && hasRd && rd != '0 && !stall && !redirect;
		end
	end

	always_ff @(posedge clk)
	begin
		exOp <= aluOp;
		exOpcode <= opcode;
		exFunc3 <= func3;
		exOperand0 <= operand0Next;
		exOperand1 <= operand1Next;
		exImm <= imm;
		exPc <= pc;
		exRd <= rd;
	end

	assign exIsLoad = exOpcode == RiscvPkg::Load;

	assign wbEnable = writeEnable;
	assign wbReg = writeNum;
	assign wbData = writeData;

	RegsFile regsFile (
		.clk        (clk),
		.rstN       (rstN),
		.readNum0   (rs1),
		.readNum1   (rs2),
		.readData0  (readData0),
		.readData1  (readData1),
		.writeEnable(writeEnable),
		.writeNum   (writeNum),
		.writeData  (writeData)
	);

	Execute execute (
		.clk        (clk),
		.rstN       (rstN),
		.exValid    (exValid),
		.exOp       (exOp),
		.exOpcode   (exOpcode),
		.exFunc3    (exFunc3),
		.operand0   (exOperand0),
		.operand1   (exOperand1),
		.imm        (exImm),
		.exPc       (exPc),
		.exRd       (exRd),
		.exWritesReg(exWritesReg),
		.aluResult  (aluResult),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.writeEnable(writeEnable),
		.writeNum   (writeNum),
		.writeData  (writeData)
	);

	Forward forward (
		.srcNum0    (rs1),
		.srcNum1    (rs2),
		.exRd       (exRd),
		.exWritesReg(exWritesReg),
		.exIsLoad   (exIsLoad),
		.wbNum      (writeNum),
		.wbEnable   (writeEnable),
		.selA       (selA),
		.selB       (selB)
	);

	Hazard hazard (
		.exValid (exValid),
		.exIsLoad(exIsLoad),
		.exRd    (exRd),
		.srcNum0 (rs1),
		.srcNum1 (rs2),
		.srcUses0(uses0),
		.srcUses1(uses1),
		.stall   (stall)
	);

	// Execute only ever sees the supported major opcodes
	ExecuteOpcodeLegal: assert property (
		@(posedge clk) disable iff (!rstN)
		exValid |-> (exOpcode inside {RiscvPkg::OpImm, RiscvPkg::Op, RiscvPkg::Lui,
			RiscvPkg::Auipc, RiscvPkg::Jal, RiscvPkg::Jalr, RiscvPkg::Branch,
			RiscvPkg::Load, RiscvPkg::Store})
	);

endmodule

// ==== src/RiscvCore.sv ====
`timescale 1ns/1ns
module RiscvCore (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic [RiscvPkg::XLEN-1:0]        instr,
	output logic [RiscvPkg::XLEN-1:0]        pc,
	output logic                             wbEnable,
	output logic [RiscvPkg::RegNumWidth-1:0] wbReg,
	output logic [RiscvPkg::XLEN-1:0]        wbData
);

	logic stall;
	logic redirect;
	logic [RiscvPkg::XLEN-1:0] redirectPc;

	FetchUnit fetchUnit (
		.clk       (clk),
		.rstN      (rstN),
		.stall     (stall),
		.redirect  (redirect),
		.redirectPc(redirectPc),
		.pc        (pc)
	);

	// Instruction arrives combinationally for the current pc
	Decode decode (
		.clk       (clk),
		.rstN      (rstN),
		.instr     (instr),
		.pc        (pc),
		.stall     (stall),
		.redirect  (redirect),
		.redirectPc(redirectPc),
		.wbEnable  (wbEnable),
		.wbReg     (wbReg),
		.wbData    (wbData)
	);

endmodule

// ==== verification/CoreTb.sv ====
`timescale 1ns/1ns
module CoreTb;

	localparam logic [31:0] Seed = 32'h48f5_2591;
	localparam int ProgLen = 48; // Random slots before the final self-jump
	localparam int ProgWords = 64;
	localparam int Timeout = 500; // Cycles
	localparam int IdleCycles = 20;
	localparam logic [31:0] Nop = 32'h0000_0013;

	// RV32I major opcodes
	localparam logic [6:0] OpcOpImm = 7'h13;
	localparam logic [6:0] OpcOp = 7'h33;
	localparam logic [6:0] OpcLui = 7'h37;
	localparam logic [6:0] OpcAuipc = 7'h17;
	localparam logic [6:0] OpcJal = 7'h6f;
	localparam logic [6:0] OpcJalr = 7'h67;
	localparam logic [6:0] OpcBranch = 7'h63;
	localparam logic [6:0] OpcLoad = 7'h03;
	localparam logic [6:0] OpcStore = 7'h23;

	logic clk;
	logic rstN;
	logic [31:0] instr;
	logic [31:0] pc;
	logic wbEnable;
	logic [4:0] wbReg;
	logic [31:0] wbData;

	logic [31:0] lcgState;
	logic [31:0] prog [ProgWords];
	logic [31:0] mReg [32]; // Model state
	logic [31:0] mMem [64];
	logic [4:0] expReg [ProgWords];
	logic [31:0] expData [ProgWords];
	int expCount;
	int wbCount;
	logic checking;

	RiscvCore UUT (
		.clk     (clk),
		.rstN    (rstN),
		.instr   (instr),
		.pc      (pc),
		.wbEnable(wbEnable),
		.wbReg   (wbReg),
		.wbData  (wbData)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic int randBelow(input int n);
		logic [31:0] r;
		r = nextRand();
		return int'(r[30:8]) % n; // Upper bits, low ones cycle fast
	endfunction

	function automatic logic [31:0] rType(input int f7, input int rs2, input int rs1,
		input int f3, input int rd);
		return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OpcOp};
	endfunction

	function automatic logic [31:0] iType(input int imm, input int rs1, input int f3,
		input int rd, input logic [6:0] op);
		return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
	endfunction

	function automatic logic [31:0] sType(input int imm, input int rs2, input int rs1);
		logic [11:0] i12;
		i12 = 12'(imm);
		return {i12[11:5], 5'(rs2), 5'(rs1), 3'b010, i12[4:0], OpcStore};
	endfunction

	function automatic logic [31:0] bType(input int off, input int rs2, input int rs1,
		input int f3);
		logic [12:0] b;
		b = 13'(off);
		return {b[12], b[10:5], 5'(rs2), 5'(rs1), 3'(f3), b[4:1], b[11], OpcBranch};
	endfunction

	function automatic logic [31:0] jType(input int off, input int rd);
		logic [20:0] j;
		j = 21'(off);
		return {j[20], j[10:1], j[11], j[19:12], 5'(rd), OpcJal};
	endfunction

	function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5:
				if (alt)
					return $signed(a) >>> b[4:0];
				else
					return a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// Mode 0 leans on ALU and control flow, mode 1 on memory traffic
	task automatic buildProgram(input int mode);
		bit targeted [ProgLen+1];
		int i;
		int kind;
		int f3;
		int rd;
		int rs1;
		int rs2;
		int tgt;
		int addr;
		for (int k = 0; k < ProgWords; k++)
			prog[k] = Nop;
		for (int k = 0; k <= ProgLen; k++)
			targeted[k] = 1'b0;
		i = 0;
		while (i < ProgLen)
		begin
			kind = randBelow(10);
			if (mode == 1 && kind < 5)
				kind = 9 + kind % 2;
			if (kind == 8 && (i + 1 >= ProgLen || targeted[i+1]))
				kind = 0; // JALR needs its base set just before
			if (kind == 10 && i + 2 >= ProgLen)
				kind = 9;
			rd = randBelow(8);
			rs1 = randBelow(8);
			rs2 = randBelow(8);
			f3 = randBelow(8);
			tgt = i + 1 + randBelow(4);
			if (tgt > ProgLen)
				tgt = ProgLen;
			addr = 4 * randBelow(16);
			case (kind)
				0, 1, 2:
					if (f3 == 1)
						prog[i] = iType(randBelow(32), rs1, f3, rd, OpcOpImm);
					else if (f3 == 5)
						prog[i] = iType(randBelow(32) + 1024 * randBelow(2), rs1, f3, rd, OpcOpImm);
					else
						prog[i] = iType(randBelow(4096), rs1, f3, rd, OpcOpImm);
				3, 4: prog[i] = rType((f3 == 0 || f3 == 5) ? 32 * randBelow(2) : 0, rs2, rs1, f3, rd);
				5: prog[i] = {20'(randBelow(1 << 20)), 5'(rd), randBelow(2) == 1 ? OpcLui : OpcAuipc};
				6:
				begin
					f3 = randBelow(6);
					prog[i] = bType((tgt - i) * 4, rs2, rs1, f3 < 2 ? f3 : f3 + 2);
					targeted[tgt] = 1'b1;
				end
				7:
				begin
					prog[i] = jType((tgt - i) * 4, rd);
					targeted[tgt] = 1'b1;
				end
				8:
				begin
					rs1 = 1 + randBelow(7);
					tgt = (tgt + 1 > ProgLen) ? ProgLen : tgt + 1;
					prog[i] = iType(tgt * 4, 0, 0, rs1, OpcOpImm);
					prog[i+1] = iType(randBelow(2), rs1, 0, rd, OpcJalr); // Bit 0 gets cleared
					targeted[tgt] = 1'b1;
					i++;
				end
				9:
					if (randBelow(2) == 1)
						prog[i] = iType(addr, 0, 2, rd, OpcLoad);
					else
						prog[i] = sType(addr, rs2, 0);
				default:
				begin
					prog[i] = sType(addr, rs2, 0); // Store, reload, then use at once
					prog[i+1] = iType(addr, 0, 2, rd, OpcLoad);
					prog[i+2] = rType(32 * randBelow(2), rs1, rd, 0, randBelow(8));
					i += 2;
				end
			endcase
			i++;
		end
		prog[ProgLen] = jType(0, 0); // Self-jump ends the program
	endtask

	task automatic runModel();
		logic [31:0] pcM;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immU;
		logic [31:0] addr;
		logic [31:0] val;
		logic [31:0] nextPc;
		logic writes;
		for (int r = 0; r < 32; r++)
			mReg[r] = '0;
		expCount = 0;
		pcM = '0;
		while (pcM < 32'(ProgLen * 4)) // Control flow only moves forward
		begin
			ins = prog[pcM[7:2]];
			a = mReg[ins[19:15]];
			b = mReg[ins[24:20]];
			immI = {{20{ins[31]}}, ins[31:20]};
			immU = {ins[31:12], 12'b0};
			nextPc = pcM + 32'd4;
			writes = 1'b1;
			val = '0;
			case (ins[6:0])
				OpcOpImm: val = aluModel(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, immI);
				OpcOp: val = aluModel(ins[14:12], ins[30], a, b);
				OpcLui: val = immU;
				OpcAuipc: val = pcM + immU;
				OpcJal:
				begin
					val = pcM + 32'd4;
					nextPc = pcM + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
				end
				OpcJalr:
				begin
					val = pcM + 32'd4;
					nextPc = (a + immI) & ~32'd1;
				end
				OpcBranch:
				begin
					writes = 1'b0;
					if (branchTaken(ins[14:12], a, b))
						nextPc = pcM + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
				end
				OpcLoad:
				begin
					addr = a + immI;
					val = mMem[addr[7:2]];
				end
				OpcStore:
				begin
					writes = 1'b0;
					addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
					mMem[addr[7:2]] = b;
				end
				default: writes = 1'b0;
			endcase
			if (writes && ins[11:7] != 5'd0)
			begin
				mReg[ins[11:7]] = val;
				expReg[expCount] = ins[11:7];
				expData[expCount] = val;
				expCount++;
			end
			pcM = nextPc;
		end
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Fail %s got %h expected %h at write %0d", name, got, exp, wbCount);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic reportProblem(input string text);
		$display("%s", text);
		$display("Some tests failed");
		$fatal(1);
	endtask

	// Instruction port answers for the current pc
	always @(negedge clk)
	begin
		if (pc < 32'(ProgWords * 4))
			instr = prog[pc[7:2]];
		else
			instr = Nop;
	end

	always @(negedge clk)
	begin
		if (checking && wbEnable)
		begin
			assert (wbCount < expCount)
			else
				reportProblem("The core wrote back more results than the model");
			assert (wbReg == expReg[wbCount])
			else
				reportMismatch("wbReg", {27'b0, wbReg}, {27'b0, expReg[wbCount]});
			assert (wbData == expData[wbCount])
			else
				reportMismatch("wbData", wbData, expData[wbCount]);
			wbCount++;
		end
	end

	initial
	begin
		int cycles;
		clk = 1'b0;
		rstN = 1'b0;
		instr = Nop;
		checking = 1'b0;
		wbCount = 0;
		lcgState = Seed;
		for (int k = 0; k < 64; k++)
			mMem[k] = '0; // Data memory keeps its contents across resets
		for (int run = 0; run < 2; run++)
		begin
			rstN = 1'b0;
			checking = 1'b0;
			buildProgram(run);
			runModel();
			repeat (3) @(negedge clk);
			wbCount = 0;
			checking = 1'b1;
			rstN = 1'b1;
			cycles = 0;
			while (wbCount < expCount && cycles < Timeout)
			begin
				@(posedge clk);
				cycles++;
			end
			assert (wbCount == expCount)
			else
				reportProblem("The core stopped writing back before the last expected result");
			for (int k = 0; k < IdleCycles; k++)
				@(posedge clk); // Quiet period after the final self-jump
			@(negedge clk);
			// Self-jump alternates between its own slot and the flushed next one
			assert (pc == 32'(ProgLen * 4) || pc == 32'(ProgLen * 4 + 4))
			else
				reportProblem($sformatf("Fail pc %h expected %h or %h", pc,
					32'(ProgLen * 4), 32'(ProgLen * 4 + 4)));
		end
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== RiscvCore.f ====
src/RiscvPkg.sv
src/DataMemory.sv
src/RegsFile.sv
src/Forward.sv
src/Hazard.sv
src/Execute.sv
src/FetchUnit.sv
src/Decode.sv
src/RiscvCore.sv
verification/CoreTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module CoreTb -f RiscvCore.f || exit 1
simOut=$(./obj_dir/VCoreTb)
echo "$simOut"
echo "$simOut" | grep -q "All tests passed" && echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }
